//--- rtl/axil_mon_pkg.sv
// Shared widths, limits and rule numbers for the AXI-lite bus monitor
// Bus widths are fixed for a 28-bit address and 32-bit data link
// Rule indices are positions in the violation flag vector
// Error responses (SLVERR, DECERR) are always legal, only EXOKAY is flagged

package axil_mon_pkg;

	////////////////////
	// Bus widths
	////////////////////
	localparam int AXI_ADDR_W = 28;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = 4;
	localparam int RESP_W     = 2;
	localparam int PROT_W     = 3;
	localparam int CACHE_W    = 4;

	// All ones in an outstanding counter counts as overflow
	localparam int CNT_W = 4;

	////////////////////
	// Timing limits
	////////////////////
	// Request channels AW, W, AR
	localparam int REQ_STALL_MAX  = 12;
	// Response channels B, R
	localparam int RESP_STALL_MAX = 8;
	// Cycles a request may wait with no response valid
	localparam int RESP_DELAY_MAX = 12;

	// Exclusive okay is never legal on AXI-lite
	localparam logic [RESP_W-1:0] RESP_EXOKAY = 2'd1;

	// Cycle stamp of the first violation
	localparam int STAMP_W = 16;

	////////////////////
	// Violation rules
	////////////////////
	localparam int VIOL_W        = 19;
	localparam int V_RESET_VALID = 0;
	localparam int V_AW_UNSTABLE = 1;
	localparam int V_W_UNSTABLE  = 2;
	localparam int V_AR_UNSTABLE = 3;
	localparam int V_R_UNSTABLE  = 4;
	localparam int V_B_UNSTABLE  = 5;
	localparam int V_AW_STALL    = 6;
	localparam int V_W_STALL     = 7;
	localparam int V_AR_STALL    = 8;
	localparam int V_R_STALL     = 9;
	localparam int V_B_STALL     = 10;
	localparam int V_WR_OVERFLOW = 11;
	localparam int V_RD_OVERFLOW = 12;
	localparam int V_B_UNMATCHED = 13;
	localparam int V_R_UNMATCHED = 14;
	localparam int V_WR_LATENCY  = 15;
	localparam int V_RD_LATENCY  = 16;
	localparam int V_ATTR        = 17;
	localparam int V_EXOKAY      = 18;

endpackage

//--- rtl/axil_channel_watch.sv
// Stability and stall-limit checker for one VALID/READY channel
// Pure observer, outputs are combinational pulses with no latency
// A stall is any sampled cycle with VALID high and READY low
// The stall pulse repeats every cycle once the limit is reached

`timescale 1ns/1ns

module axil_channel_watch #(
	parameter int P_PAYLOAD_W = 8,
	parameter int P_STALL_MAX = 12
) (
	input  logic                   i_clk,
	input  logic                   i_axi_reset_n,
	input  logic                   i_valid,
	input  logic                   i_ready,
	input  logic [P_PAYLOAD_W-1:0] i_payload,
	output logic                   o_unstable,
	output logic                   o_stall_late
);

	// Wide enough to hold the limit itself
	localparam int CW = $clog2(P_STALL_MAX + 1);

	logic                   stall_now;
	logic                   prev_stall;
	logic [P_PAYLOAD_W-1:0] prev_payload;
	logic [CW-1:0]          stall_cnt;

	assign stall_now = i_valid && !i_ready;

	// Stalled last cycle, so VALID and payload must hold
	assign o_unstable = prev_stall && (!i_valid || (i_payload != prev_payload));

	// Counter holds stalls up to the previous edge, this one adds the last
	assign o_stall_late = stall_now && (stall_cnt >= CW'(P_STALL_MAX - 1));

	// Payload history
	always_ff @(posedge i_clk)
	begin
		prev_payload <= i_payload;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			prev_stall <= 1'b0;
			stall_cnt  <= '0;
		end
		else
		begin
			prev_stall <= stall_now;
			// Any accept or idle cycle ends the run
			if (!stall_now)
				stall_cnt <= '0;
			else if (stall_cnt != CW'(P_STALL_MAX))
				stall_cnt <= stall_cnt + 1'b1;
		end
	end

	// Saturation keeps the run count at or below the limit
	a_stall_cnt_bound: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		stall_cnt <= CW'(P_STALL_MAX));

endmodule

//--- rtl/axil_txn_counter.sv
// Outstanding transaction counter for one request/response pair
// Request and acknowledge are handshakes (VALID and READY) formed outside
// The count saturates at all ones and at zero, it never wraps
// Overflow fires once the count is one step from saturation

`timescale 1ns/1ns

module axil_txn_counter (
	input  logic                           i_clk,
	input  logic                           i_axi_reset_n,
	input  logic                           i_req,
	input  logic                           i_ack,
	output logic [axil_mon_pkg::CNT_W-1:0] o_count,
	output logic                           o_overflow,
	output logic                           o_unmatched
);

	logic at_top;
	logic at_zero;

	// All ones minus one or above
	assign at_top  = (o_count >= {{(axil_mon_pkg::CNT_W - 1){1'b1}}, 1'b0});
	assign at_zero = (o_count == '0);

	assign o_overflow  = i_req && at_top;
	// Response with nothing outstanding
	assign o_unmatched = i_ack && at_zero;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_count <= '0;
		else
		begin
			case ({i_req, i_ack})
				2'b10:
					if (!(&o_count))
						o_count <= o_count + 1'b1;
				2'b01:
					if (!at_zero)
						o_count <= o_count - 1'b1;
				// Count holds on both or neither
				default:
					o_count <= o_count;
			endcase
		end
	end

	// At most one step per cycle, in either direction
	a_count_step: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		$past(i_axi_reset_n) |-> (o_count == $past(o_count))
			|| (o_count == $past(o_count) + 1'b1)
			|| (o_count == $past(o_count) - 1'b1));

endmodule

//--- rtl/axil_resp_timer.sv
// Response latency timers for the write and read paths
// A timer runs only while requests are outstanding and no response is valid
// A valid response restarts the timer even if it is not yet accepted
// The late pulse repeats each cycle while the timer sits at the limit

`timescale 1ns/1ns

module axil_resp_timer (
	input  logic                           i_clk,
	input  logic                           i_axi_reset_n,
	input  logic [axil_mon_pkg::CNT_W-1:0] i_awr_count,
	input  logic [axil_mon_pkg::CNT_W-1:0] i_wr_count,
	input  logic [axil_mon_pkg::CNT_W-1:0] i_rd_count,
	input  logic                           i_bvalid,
	input  logic                           i_rvalid,
	output logic                           o_wr_late,
	output logic                           o_rd_late
);

	localparam int TW = $clog2(axil_mon_pkg::RESP_DELAY_MAX + 1);

	logic          wr_clear;
	logic          rd_clear;
	logic [TW-1:0] wr_timer;
	logic [TW-1:0] rd_timer;

	// Next timer value, saturating at the delay limit
	function automatic logic [TW-1:0] timer_next(input logic clr, input logic [TW-1:0] cur);
		logic [TW-1:0] nxt;
		if (clr)
			nxt = '0;
		else if (cur == TW'(axil_mon_pkg::RESP_DELAY_MAX))
			nxt = cur;
		else
			nxt = cur + 1'b1;
		return nxt;
	endfunction

	// Write waits until both address and data are in
	assign wr_clear = i_bvalid || (i_awr_count == '0) || (i_wr_count == '0);
	assign rd_clear = i_rvalid || (i_rd_count == '0);

	assign o_wr_late = (wr_timer == TW'(axil_mon_pkg::RESP_DELAY_MAX));
	assign o_rd_late = (rd_timer == TW'(axil_mon_pkg::RESP_DELAY_MAX));

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			wr_timer <= '0;
			rd_timer <= '0;
		end
		else
		begin
			wr_timer <= timer_next(wr_clear, wr_timer);
			rd_timer <= timer_next(rd_clear, rd_timer);
		end
	end

endmodule

//--- rtl/axil_mon_ctrl.sv
// Collects checker pulses into the violation vector and keeps records
// One register stage, every output lags the sampled breach by one cycle
// First rule and stamp are only meaningful while o_first_valid is high
// Stamp counts edges since reset and wraps at STAMP_W bits

`timescale 1ns/1ns

module axil_mon_ctrl (
	input  logic                                     i_clk,
	input  logic                                     i_axi_reset_n,
	// Bus signals
	input  logic                                     i_awvalid,
	input  logic                                     i_wvalid,
	input  logic                                     i_arvalid,
	input  logic                                     i_bvalid,
	input  logic                                     i_rvalid,
	input  logic [axil_mon_pkg::PROT_W-1:0]          i_awprot,
	input  logic [axil_mon_pkg::PROT_W-1:0]          i_arprot,
	input  logic [axil_mon_pkg::CACHE_W-1:0]         i_awcache,
	input  logic [axil_mon_pkg::CACHE_W-1:0]         i_arcache,
	input  logic [axil_mon_pkg::RESP_W-1:0]          i_bresp,
	input  logic [axil_mon_pkg::RESP_W-1:0]          i_rresp,
	// Checker pulses
	input  logic                                     i_aw_unstable,
	input  logic                                     i_w_unstable,
	input  logic                                     i_ar_unstable,
	input  logic                                     i_r_unstable,
	input  logic                                     i_b_unstable,
	input  logic                                     i_aw_stall,
	input  logic                                     i_w_stall,
	input  logic                                     i_ar_stall,
	input  logic                                     i_r_stall,
	input  logic                                     i_b_stall,
	input  logic                                     i_wr_overflow,
	input  logic                                     i_rd_overflow,
	input  logic                                     i_b_unmatched,
	input  logic                                     i_r_unmatched,
	input  logic                                     i_wr_late,
	input  logic                                     i_rd_late,
	// Reports
	output logic                                     o_violation,
	output logic [axil_mon_pkg::VIOL_W-1:0]          o_violation_flags,
	output logic [axil_mon_pkg::VIOL_W-1:0]          o_sticky_flags,
	output logic                                     o_first_valid,
	output logic [$clog2(axil_mon_pkg::VIOL_W)-1:0]  o_first_rule,
	output logic [axil_mon_pkg::STAMP_W-1:0]         o_first_stamp
);

	localparam int RULE_W = $clog2(axil_mon_pkg::VIOL_W);

	logic                              just_reset;
	logic                              any_valid;
	logic                              attr_bad;
	logic                              exokay;
	logic [axil_mon_pkg::VIOL_W-1:0]   viol_now;
	logic [axil_mon_pkg::STAMP_W-1:0]  stamp;

	// Lowest set rule wins when several fire together
	function automatic logic [RULE_W-1:0] lowest_rule(input logic [axil_mon_pkg::VIOL_W-1:0] f);
		logic [RULE_W-1:0] idx;
		idx = '0;
		for (int k = axil_mon_pkg::VIOL_W - 1; k >= 0; k--)
			if (f[k])
				idx = RULE_W'(k);
		return idx;
	endfunction

	assign any_valid = i_awvalid || i_wvalid || i_arvalid || i_bvalid || i_rvalid;

	// AxPROT and AxCACHE must read zero while their VALID is up
	assign attr_bad = (i_awvalid && ((i_awprot != '0) || (i_awcache != '0)))
		|| (i_arvalid && ((i_arprot != '0) || (i_arcache != '0)));

	assign exokay = (i_bvalid && (i_bresp == axil_mon_pkg::RESP_EXOKAY))
		|| (i_rvalid && (i_rresp == axil_mon_pkg::RESP_EXOKAY));

	////////////////////
	// Rule vector
	////////////////////
	always_comb
	begin
		viol_now = '0;
		viol_now[axil_mon_pkg::V_RESET_VALID] = just_reset && any_valid;
		viol_now[axil_mon_pkg::V_AW_UNSTABLE] = i_aw_unstable;
		viol_now[axil_mon_pkg::V_W_UNSTABLE]  = i_w_unstable;
		viol_now[axil_mon_pkg::V_AR_UNSTABLE] = i_ar_unstable;
		viol_now[axil_mon_pkg::V_R_UNSTABLE]  = i_r_unstable;
		viol_now[axil_mon_pkg::V_B_UNSTABLE]  = i_b_unstable;
		viol_now[axil_mon_pkg::V_AW_STALL]    = i_aw_stall;
		viol_now[axil_mon_pkg::V_W_STALL]     = i_w_stall;
		viol_now[axil_mon_pkg::V_AR_STALL]    = i_ar_stall;
		viol_now[axil_mon_pkg::V_R_STALL]     = i_r_stall;
		viol_now[axil_mon_pkg::V_B_STALL]     = i_b_stall;
		viol_now[axil_mon_pkg::V_WR_OVERFLOW] = i_wr_overflow;
		viol_now[axil_mon_pkg::V_RD_OVERFLOW] = i_rd_overflow;
		viol_now[axil_mon_pkg::V_B_UNMATCHED] = i_b_unmatched;
		viol_now[axil_mon_pkg::V_R_UNMATCHED] = i_r_unmatched;
		viol_now[axil_mon_pkg::V_WR_LATENCY]  = i_wr_late;
		viol_now[axil_mon_pkg::V_RD_LATENCY]  = i_rd_late;
		viol_now[axil_mon_pkg::V_ATTR]        = attr_bad;
		viol_now[axil_mon_pkg::V_EXOKAY]      = exokay;
	end

	////////////////////
	// Records
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			// High for exactly the first cycle out of reset
			just_reset        <= 1'b1;
			stamp             <= '0;
			o_violation       <= 1'b0;
			o_violation_flags <= '0;
			o_sticky_flags    <= '0;
			o_first_valid     <= 1'b0;
		end
		else
		begin
			just_reset        <= 1'b0;
			stamp             <= stamp + 1'b1;
			o_violation       <= |viol_now;
			o_violation_flags <= viol_now;
			o_sticky_flags    <= o_sticky_flags | viol_now;
			if (|viol_now)
				o_first_valid <= 1'b1;
		end
	end

	// Capture only once per reset
	always_ff @(posedge i_clk)
	begin
		if (!o_first_valid && (|viol_now) && i_axi_reset_n)
		begin
			o_first_rule  <= lowest_rule(viol_now);
			o_first_stamp <= stamp;
		end
	end

	a_strobe_flags: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		o_violation == (|o_violation_flags));

endmodule

//--- rtl/axil_bus_monitor.sv
// AXI-lite bus monitor, observes a master-to-slave link and never drives it
// Every rule is judged on inputs sampled at the rising edge of i_clk
// o_violation and the flag vectors lag the breach by one cycle
// Outstanding counts update at the edge where the handshake is sampled
// Synchronous active-low reset clears counts, flags and records

`timescale 1ns/1ns

module axil_bus_monitor (
	input  logic                                     i_clk,
	input  logic                                     i_axi_reset_n,
	// Write address
	input  logic                                     i_axi_awready,
	input  logic [axil_mon_pkg::AXI_ADDR_W-1:0]      i_axi_awaddr,
	input  logic [axil_mon_pkg::CACHE_W-1:0]         i_axi_awcache,
	input  logic [axil_mon_pkg::PROT_W-1:0]          i_axi_awprot,
	input  logic                                     i_axi_awvalid,
	// Write data
	input  logic                                     i_axi_wready,
	input  logic [axil_mon_pkg::AXI_DATA_W-1:0]      i_axi_wdata,
	input  logic [axil_mon_pkg::AXI_STRB_W-1:0]      i_axi_wstrb,
	input  logic                                     i_axi_wvalid,
	// Write response
	input  logic [axil_mon_pkg::RESP_W-1:0]          i_axi_bresp,
	input  logic                                     i_axi_bvalid,
	input  logic                                     i_axi_bready,
	// Read address
	input  logic                                     i_axi_arready,
	input  logic [axil_mon_pkg::AXI_ADDR_W-1:0]      i_axi_araddr,
	input  logic [axil_mon_pkg::CACHE_W-1:0]         i_axi_arcache,
	input  logic [axil_mon_pkg::PROT_W-1:0]          i_axi_arprot,
	input  logic                                     i_axi_arvalid,
	// Read data
	input  logic [axil_mon_pkg::RESP_W-1:0]          i_axi_rresp,
	input  logic                                     i_axi_rvalid,
	input  logic [axil_mon_pkg::AXI_DATA_W-1:0]      i_axi_rdata,
	input  logic                                     i_axi_rready,
	// Counts and reports
	output logic [axil_mon_pkg::CNT_W-1:0]           o_awr_outstanding,
	output logic [axil_mon_pkg::CNT_W-1:0]           o_wr_outstanding,
	output logic [axil_mon_pkg::CNT_W-1:0]           o_rd_outstanding,
	output logic                                     o_violation,
	output logic [axil_mon_pkg::VIOL_W-1:0]          o_violation_flags,
	output logic [axil_mon_pkg::VIOL_W-1:0]          o_sticky_flags,
	output logic                                     o_first_valid,
	output logic [$clog2(axil_mon_pkg::VIOL_W)-1:0]  o_first_rule,
	output logic [axil_mon_pkg::STAMP_W-1:0]         o_first_stamp
);

	// Handshakes
	logic aw_hs, w_hs, ar_hs, b_hs, r_hs;
	// Checker pulses
	logic aw_unstable, w_unstable, ar_unstable, r_unstable, b_unstable;
	logic aw_stall, w_stall, ar_stall, r_stall, b_stall;
	logic wr_overflow, rd_overflow, b_unmatched, r_unmatched;
	logic wr_late, rd_late;

	assign aw_hs = i_axi_awvalid && i_axi_awready;
	assign w_hs  = i_axi_wvalid && i_axi_wready;
	assign ar_hs = i_axi_arvalid && i_axi_arready;
	assign b_hs  = i_axi_bvalid && i_axi_bready;
	assign r_hs  = i_axi_rvalid && i_axi_rready;

	////////////////////
	// Channel watches
	////////////////////
	axil_channel_watch #(
		.P_PAYLOAD_W(axil_mon_pkg::AXI_ADDR_W), .P_STALL_MAX(axil_mon_pkg::REQ_STALL_MAX)
	) u_aw_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_axi_awvalid), .i_ready(i_axi_awready), .i_payload(i_axi_awaddr),
		.o_unstable(aw_unstable), .o_stall_late(aw_stall)
	);

	// Data and strobe checked as one word
	axil_channel_watch #(
		.P_PAYLOAD_W(axil_mon_pkg::AXI_DATA_W + axil_mon_pkg::AXI_STRB_W),
		.P_STALL_MAX(axil_mon_pkg::REQ_STALL_MAX)
	) u_w_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_axi_wvalid), .i_ready(i_axi_wready),
		.i_payload({i_axi_wdata, i_axi_wstrb}),
		.o_unstable(w_unstable), .o_stall_late(w_stall)
	);

	axil_channel_watch #(
		.P_PAYLOAD_W(axil_mon_pkg::AXI_ADDR_W), .P_STALL_MAX(axil_mon_pkg::REQ_STALL_MAX)
	) u_ar_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_axi_arvalid), .i_ready(i_axi_arready), .i_payload(i_axi_araddr),
		.o_unstable(ar_unstable), .o_stall_late(ar_stall)
	);

	axil_channel_watch #(
		.P_PAYLOAD_W(axil_mon_pkg::AXI_DATA_W + axil_mon_pkg::RESP_W),
		.P_STALL_MAX(axil_mon_pkg::RESP_STALL_MAX)
	) u_r_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_axi_rvalid), .i_ready(i_axi_rready),
		.i_payload({i_axi_rdata, i_axi_rresp}),
		.o_unstable(r_unstable), .o_stall_late(r_stall)
	);

	axil_channel_watch #(
		.P_PAYLOAD_W(axil_mon_pkg::RESP_W), .P_STALL_MAX(axil_mon_pkg::RESP_STALL_MAX)
	) u_b_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_axi_bvalid), .i_ready(i_axi_bready), .i_payload(i_axi_bresp),
		.o_unstable(b_unstable), .o_stall_late(b_stall)
	);

	////////////////////
	// Outstanding counts
	////////////////////
	// Address side owns write overflow
	axil_txn_counter u_awr_cnt (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_req(aw_hs), .i_ack(b_hs),
		.o_count(o_awr_outstanding), .o_overflow(wr_overflow), .o_unmatched()
	);

	// Data side owns the unmatched B check
	axil_txn_counter u_wr_cnt (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_req(w_hs), .i_ack(b_hs),
		.o_count(o_wr_outstanding), .o_overflow(), .o_unmatched(b_unmatched)
	);

	axil_txn_counter u_rd_cnt (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_req(ar_hs), .i_ack(r_hs),
		.o_count(o_rd_outstanding), .o_overflow(rd_overflow), .o_unmatched(r_unmatched)
	);

	axil_resp_timer u_resp_timer (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_awr_count(o_awr_outstanding), .i_wr_count(o_wr_outstanding),
		.i_rd_count(o_rd_outstanding),
		.i_bvalid(i_axi_bvalid), .i_rvalid(i_axi_rvalid),
		.o_wr_late(wr_late), .o_rd_late(rd_late)
	);

	////////////////////
	// Collection
	////////////////////
	axil_mon_ctrl u_ctrl (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_awvalid(i_axi_awvalid), .i_wvalid(i_axi_wvalid), .i_arvalid(i_axi_arvalid),
		.i_bvalid(i_axi_bvalid), .i_rvalid(i_axi_rvalid),
		.i_awprot(i_axi_awprot), .i_arprot(i_axi_arprot),
		.i_awcache(i_axi_awcache), .i_arcache(i_axi_arcache),
		.i_bresp(i_axi_bresp), .i_rresp(i_axi_rresp),
		.i_aw_unstable(aw_unstable), .i_w_unstable(w_unstable),
		.i_ar_unstable(ar_unstable), .i_r_unstable(r_unstable),
		.i_b_unstable(b_unstable),
		.i_aw_stall(aw_stall), .i_w_stall(w_stall), .i_ar_stall(ar_stall),
		.i_r_stall(r_stall), .i_b_stall(b_stall),
		.i_wr_overflow(wr_overflow), .i_rd_overflow(rd_overflow),
		.i_b_unmatched(b_unmatched), .i_r_unmatched(r_unmatched),
		.i_wr_late(wr_late), .i_rd_late(rd_late),
		.o_violation(o_violation), .o_violation_flags(o_violation_flags),
		.o_sticky_flags(o_sticky_flags), .o_first_valid(o_first_valid),
		.o_first_rule(o_first_rule), .o_first_stamp(o_first_stamp)
	);

endmodule

//--- dv/axil_mon_vectors.svh
// Stimulus table for the AXI-lite bus monitor testbench
// Each row is held for reps cycles and checked after every sampled edge
// Flags are checked on every cycle of a row, counts on its last cycle only
// Payload words come from the LFSR when f is set, otherwise they hold

// Columns: test, reps, {rst, awv awr, wv wr, bv br, arv arr, rv rr, f},
//          awprot, bresp, exp awr count, exp wr count, exp rd count, exp flags
task automatic load_table();
	////////////////////
	// 1 clean traffic
	////////////////////
	add_row(1, 2,  12'b1_00_00_00_00_00_0, 0, 0, 0, 0, 0, 19'h00000);
	add_row(1, 1,  12'b0_00_00_00_00_00_1, 0, 0, 0, 0, 0, 19'h00000);
	add_row(1, 1,  12'b0_11_11_00_00_00_1, 0, 0, 1, 1, 0, 19'h00000);
	// AW stalled three cycles with the address held
	add_row(1, 3,  12'b0_10_00_00_00_00_0, 0, 0, 1, 1, 0, 19'h00000);
	add_row(1, 1,  12'b0_11_11_00_00_00_0, 0, 0, 2, 2, 0, 19'h00000);
	add_row(1, 1,  12'b0_00_00_11_00_00_1, 0, 0, 1, 1, 0, 19'h00000);
	add_row(1, 1,  12'b0_00_00_11_00_00_1, 0, 0, 0, 0, 0, 19'h00000);
	add_row(1, 1,  12'b0_00_00_00_11_00_1, 0, 0, 0, 0, 1, 19'h00000);
	add_row(1, 2,  12'b0_00_00_00_00_10_0, 0, 0, 0, 0, 1, 19'h00000);
	add_row(1, 1,  12'b0_00_00_00_00_11_0, 0, 0, 0, 0, 0, 19'h00000);
	add_row(1, 2,  12'b0_00_00_00_10_00_0, 0, 0, 0, 0, 0, 19'h00000);
	add_row(1, 1,  12'b0_00_00_00_11_00_0, 0, 0, 0, 0, 1, 19'h00000);
	add_row(1, 1,  12'b0_00_00_00_00_11_1, 0, 0, 0, 0, 0, 19'h00000);
	////////////////////
	// 2 reset valid, attribute, exokay
	////////////////////
	add_row(2, 2,  12'b1_00_00_00_00_00_0, 0, 0, 0, 0, 0, 19'h00000);
	add_row(2, 1,  12'b0_11_00_00_00_00_1, 0, 0, 1, 0, 0, 19'h00001);
	add_row(2, 1,  12'b0_11_00_00_00_00_1, 2, 0, 2, 0, 0, 19'h20000);
	add_row(2, 1,  12'b0_00_11_00_00_00_1, 0, 0, 2, 1, 0, 19'h00000);
	add_row(2, 1,  12'b0_00_00_11_00_00_1, 0, 1, 1, 0, 0, 19'h40000);
	////////////////////
	// 3 unstable W and R
	////////////////////
	add_row(3, 2,  12'b1_00_00_00_00_00_0, 0, 0, 0, 0, 0, 19'h00000);
	add_row(3, 1,  12'b0_00_00_00_00_00_1, 0, 0, 0, 0, 0, 19'h00000);
	add_row(3, 1,  12'b0_00_10_00_00_00_1, 0, 0, 0, 0, 0, 19'h00000);
	add_row(3, 1,  12'b0_00_10_00_00_00_1, 0, 0, 0, 0, 0, 19'h00004);
	add_row(3, 1,  12'b0_00_00_00_00_00_0, 0, 0, 0, 0, 0, 19'h00004);
	add_row(3, 1,  12'b0_00_00_00_00_10_1, 0, 0, 0, 0, 0, 19'h00000);
	add_row(3, 1,  12'b0_00_00_00_00_10_1, 0, 0, 0, 0, 0, 19'h00010);
	add_row(3, 1,  12'b0_00_00_00_00_00_0, 0, 0, 0, 0, 0, 19'h00010);
	////////////////////
	// 4 stall limits on AR and B
	////////////////////
	add_row(4, 2,  12'b1_00_00_00_00_00_0, 0, 0, 0, 0, 0, 19'h00000);
	add_row(4, 1,  12'b0_00_00_00_00_00_1, 0, 0, 0, 0, 0, 19'h00000);
	add_row(4, 1,  12'b0_00_00_00_10_00_1, 0, 0, 0, 0, 0, 19'h00000);
	add_row(4, 10, 12'b0_00_00_00_10_00_0, 0, 0, 0, 0, 0, 19'h00000);
	add_row(4, 1,  12'b0_00_00_00_10_00_0, 0, 0, 0, 0, 0, 19'h00100);
	add_row(4, 1,  12'b0_00_00_00_11_00_0, 0, 0, 0, 0, 1, 19'h00000);
	add_row(4, 1,  12'b0_00_00_00_00_11_1, 0, 0, 0, 0, 0, 19'h00000);
	add_row(4, 1,  12'b0_11_11_00_00_00_1, 0, 0, 1, 1, 0, 19'h00000);
	add_row(4, 1,  12'b0_00_00_10_00_00_1, 0, 0, 1, 1, 0, 19'h00000);
	add_row(4, 6,  12'b0_00_00_10_00_00_0, 0, 0, 1, 1, 0, 19'h00000);
	add_row(4, 1,  12'b0_00_00_10_00_00_0, 0, 0, 1, 1, 0, 19'h00400);
	add_row(4, 1,  12'b0_00_00_11_00_00_0, 0, 0, 0, 0, 0, 19'h00000);
	////////////////////
	// 5 unmatched R, read latency, first record
	////////////////////
	add_row(5, 2,  12'b1_00_00_00_00_00_0, 0, 0, 0, 0, 0, 19'h00000);
	add_row(5, 1,  12'b0_00_00_00_00_00_1, 0, 0, 0, 0, 0, 19'h00000);
	add_row(5, 1,  12'b0_00_00_00_00_11_1, 0, 0, 0, 0, 0, 19'h04000);
	add_row(5, 1,  12'b0_00_00_00_11_00_1, 0, 0, 0, 0, 1, 19'h00000);
	add_row(5, 12, 12'b0_00_00_00_00_00_1, 0, 0, 0, 0, 1, 19'h00000);
	add_row(5, 1,  12'b0_00_00_00_00_00_1, 0, 0, 0, 0, 1, 19'h10000);
	add_row(5, 1,  12'b0_00_00_00_00_11_1, 0, 0, 0, 0, 0, 19'h10000);
	add_row(5, 1,  12'b0_11_00_00_00_00_1, 1, 0, 1, 0, 0, 19'h20000);
	////////////////////
	// 6 read counter overflow and saturation
	////////////////////
	add_row(6, 2,  12'b1_00_00_00_00_00_0, 0, 0, 0, 0, 0, 19'h00000);
	add_row(6, 1,  12'b0_00_00_00_00_00_1, 0, 0, 0, 0, 0, 19'h00000);
	add_row(6, 13, 12'b0_00_00_00_11_00_1, 0, 0, 0, 0, 13, 19'h00000);
	add_row(6, 1,  12'b0_00_00_00_11_00_1, 0, 0, 0, 0, 14, 19'h10000);
	add_row(6, 1,  12'b0_00_00_00_11_00_1, 0, 0, 0, 0, 15, 19'h11000);
	add_row(6, 1,  12'b0_00_00_00_11_00_1, 0, 0, 0, 0, 15, 19'h11000);
endtask

//--- dv/axil_bus_monitor_tb.sv
// Testbench for the AXI-lite bus monitor
// Inputs change 1 ns after the rising edge, outputs are read 1 ns after it
// Expected records (sticky, first rule, stamp) follow from the table flags

`timescale 1ns/1ns

module axil_bus_monitor_tb;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        awready, awvalid, wready, wvalid, bvalid, bready;
	logic        arready, arvalid, rvalid, rready;
	logic [27:0] awaddr, araddr;
	logic [3:0]  awcache, arcache, wstrb;
	logic [2:0]  awprot, arprot;
	logic [31:0] wdata, rdata;
	logic [1:0]  bresp, rresp;
	logic [3:0]  awr_cnt, wr_cnt, rd_cnt;
	logic        viol, first_valid;
	logic [18:0] flags, sticky;
	logic [4:0]  first_rule;
	logic [15:0] first_stamp;

	// Table columns
	int          t_test[$], t_reps[$], t_awr[$], t_wr[$], t_rd[$];
	logic [11:0] t_ctl[$];
	logic [2:0]  t_awprot[$];
	logic [1:0]  t_bresp[$];
	logic [18:0] t_flags[$];

	logic [15:0] lfsr = 16'd17947;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          limit = 0;

	// Reference records
	logic [18:0] exp_sticky;
	logic        exp_first;
	int          exp_rule, exp_stamp, stamp_ctr;

	axil_bus_monitor DUT (
		.i_clk(clk), .i_axi_reset_n(rst_n),
		.i_axi_awready(awready), .i_axi_awaddr(awaddr), .i_axi_awcache(awcache),
		.i_axi_awprot(awprot), .i_axi_awvalid(awvalid),
		.i_axi_wready(wready), .i_axi_wdata(wdata), .i_axi_wstrb(wstrb),
		.i_axi_wvalid(wvalid),
		.i_axi_bresp(bresp), .i_axi_bvalid(bvalid), .i_axi_bready(bready),
		.i_axi_arready(arready), .i_axi_araddr(araddr), .i_axi_arcache(arcache),
		.i_axi_arprot(arprot), .i_axi_arvalid(arvalid),
		.i_axi_rresp(rresp), .i_axi_rvalid(rvalid), .i_axi_rdata(rdata),
		.i_axi_rready(rready),
		.o_awr_outstanding(awr_cnt), .o_wr_outstanding(wr_cnt), .o_rd_outstanding(rd_cnt),
		.o_violation(viol), .o_violation_flags(flags), .o_sticky_flags(sticky),
		.o_first_valid(first_valid), .o_first_rule(first_rule),
		.o_first_stamp(first_stamp)
	);

	always #4 clk = ~clk;

	task automatic add_row(input int test, input int reps, input logic [11:0] ctl,
		input logic [2:0] prot, input logic [1:0] resp, input int awr, input int wr,
		input int rd, input logic [18:0] fl);
		t_test.push_back(test);
		t_reps.push_back(reps);
		t_ctl.push_back(ctl);
		t_awprot.push_back(prot);
		t_bresp.push_back(resp);
		t_awr.push_back(awr);
		t_wr.push_back(wr);
		t_rd.push_back(rd);
		t_flags.push_back(fl);
	endtask

	`include "axil_mon_vectors.svh"

	// Fibonacci LFSR with taps 16 14 13 11 and one step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int lowest_set_bit(input logic [18:0] v);
		for (int k = 0; k < 19; k++)
			if (v[k])
				return k;
		return 0;
	endfunction

	task automatic compare(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic drive_row(input int i);
		logic [11:0] c;
		c = t_ctl[i];
		rst_n   = !c[11];
		awvalid = c[10];
		awready = c[9];
		wvalid  = c[8];
		wready  = c[7];
		bvalid  = c[6];
		bready  = c[5];
		arvalid = c[4];
		arready = c[3];
		rvalid  = c[2];
		rready  = c[1];
		awprot  = t_awprot[i];
		bresp   = t_bresp[i];
		// Fresh payload on every channel at once
		if (c[0])
		begin
			awaddr = 28'(random_bits(28));
			wdata  = random_bits(32);
			wstrb  = 4'(random_bits(4));
			araddr = 28'(random_bits(28));
			rdata  = random_bits(32);
		end
	endtask

	task automatic check_row(input int i, input bit last);
		compare("violation flags", 32'(flags), 32'(t_flags[i]));
		compare("violation strobe", 32'(viol), 32'(|t_flags[i]));
		if (last)
		begin
			compare("awr count", 32'(awr_cnt), t_awr[i]);
			compare("wr count", 32'(wr_cnt), t_wr[i]);
			compare("rd count", 32'(rd_cnt), t_rd[i]);
		end
		if (t_ctl[i][11])
		begin
			exp_sticky = '0;
			exp_first  = 1'b0;
			stamp_ctr  = 0;
		end
		else
		begin
			if (!exp_first && (t_flags[i] != '0))
			begin
				exp_first = 1'b1;
				exp_rule  = lowest_set_bit(t_flags[i]);
				exp_stamp = stamp_ctr;
			end
			exp_sticky = exp_sticky | t_flags[i];
			stamp_ctr++;
		end
		compare("sticky flags", 32'(sticky), 32'(exp_sticky));
		compare("first valid", 32'(first_valid), 32'(exp_first));
		if (exp_first)
		begin
			compare("first rule", 32'(first_rule), exp_rule);
			compare("first stamp", 32'(first_stamp), exp_stamp);
		end
	endtask

	// Guard against a stuck run
	always @(posedge clk)
	begin
		cycles++;
		if ((limit > 0) && (cycles >= limit))
		begin
			$display("Timeout after %0d cycles, the table did not finish", cycles);
			$display("test failed");
			$finish;
		end
	end

	initial
	begin
		int test_errors;
		rst_n = 1'b0;
		{awvalid, awready, wvalid, wready, bvalid, bready} = '0;
		{arvalid, arready, rvalid, rready} = '0;
		{awaddr, araddr, wdata, rdata, wstrb} = '0;
		{awcache, arcache, awprot, arprot, bresp, rresp} = '0;
		load_table();
		foreach (t_reps[i])
			limit += t_reps[i];
		limit += 20;
		test_errors = 0;
		@(posedge clk);
		#1;
		foreach (t_test[i])
		begin
			for (int r = 0; r < t_reps[i]; r++)
			begin
				drive_row(i);
				@(posedge clk);
				#1;
				check_row(i, r == t_reps[i] - 1);
			end
			if ((i == t_test.size() - 1) || (t_test[i + 1] != t_test[i]))
			begin
				$display("Test %0d finished with %0d errors", t_test[i], errors - test_errors);
				test_errors = errors;
			end
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- all.f
+incdir+dv
rtl/axil_mon_pkg.sv
rtl/axil_channel_watch.sv
rtl/axil_txn_counter.sv
rtl/axil_resp_timer.sv
rtl/axil_mon_ctrl.sv
rtl/axil_bus_monitor.sv
dv/axil_bus_monitor_tb.sv

//--- run_sim.sh
#!/bin/bash
# Builds and runs the bus monitor testbench with Verilator
# Pass or fail is read from the simulation log

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module axil_bus_monitor_tb -f all.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^test passed$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
